// File: common/hook_cfg.svh
//****************************************
// Hook geometry constants
// Anchor, radius, step counts and angles
//****************************************

`ifndef HOOK_CFG_SVH
`define HOOK_CFG_SVH

// Rope anchor on screen
`define HOOK_START_X     160
`define HOOK_START_Y     45

`define HOOK_RADIUS      20
`define HOOK_TRIG_SCALE  100   // Trig magnitudes are x100

`define HOOK_ROPE_STEPS  256   // Rope fraction in 1/256 units
`define HOOK_ARC_STEP    5     // Degrees per arc point
`define HOOK_ARC_STEPS   72

`define HOOK_TIP_OFFSET  20    // Added to degree for the tip direction
`define HOOK_GAP         40    // Mouth opening in degrees
`define HOOK_FULL_TURN   360

`endif

// File: common/hook_pkg.sv
//****************************************
// Shared types for the hook renderer
// Draw states, screen coordinates,
// trig lookup result and step index
//****************************************

package hookPkg;

    // Drawing sequence
    typedef enum logic [2:0] {
        Idle  = 3'd0,
        Setup = 3'd1,
        Rope  = 3'd2,
        Arc   = 3'd3,
        Done  = 3'd4
    } drawState;

    typedef logic [8:0] xCoord;  // 0 to 319
    typedef logic [7:0] yCoord;  // 0 to 239

    // Magnitudes scaled by 100, signs kept apart
    typedef struct packed {
        logic [6:0] cosMag;
        logic [6:0] sinMag;
        logic       cosNeg;
        logic       sinNeg;
    } trigPair;

    typedef logic [7:0] stepCount;

endpackage

// File: common/step_if.sv
//****************************************
// Step counter bus
// Clear/advance controls, count, end flags
//****************************************

interface stepBus import hookPkg::*; ();

    logic     clear;    // Zero the count on next edge
    logic     advance;  // Increment on next edge
    stepCount count;
    logic     ropeEnd;
    logic     arcEnd;

    // Sequencer side
    modport ctrl (output clear, output advance, input ropeEnd, input arcEnd);

    // Counter side
    modport cnt (input clear, input advance, output count, output ropeEnd, output arcEnd);

    // Point generators only need the index
    modport user (input count);

endinterface

// File: hook/hook_draw_fsm.sv
//****************************************
// Draw sequencer FSM
// Idle, setup, rope, arc and done phases
//****************************************

module hookDrawFsm import hookPkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     enable,
    stepBus.ctrl     step,
    output drawState state
);

    drawState nextState;

    // Next state decode
    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (enable) begin
                    nextState = Setup;
                end
            end
            Setup: begin
                nextState = Rope;
            end
            Rope: begin
                if (step.ropeEnd) begin
                    nextState = Arc;
                end
            end
            Arc: begin
                if (step.arcEnd) begin
                    nextState = Done;
                end
            end
            Done: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Counter restarts before the rope and again before the arc
    assign step.clear = (state == Setup) || ((state == Rope) && step.ropeEnd);

    assign step.advance = (state == Rope) || (state == Arc);

endmodule

// File: hook/step_counter.sv
//****************************************
// Shared step counter
// Rope and arc end detection
//****************************************

`include "hook_cfg.svh"

module stepCounter import hookPkg::*; (
    input  logic clock,
    input  logic resetn,
    stepBus.cnt  step
);

    stepCount index;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            index <= '0;
        end else if (step.clear) begin
            index <= '0;  // Clear wins over advance
        end else if (step.advance) begin
            index <= index + stepCount'(1);
        end
    end

    assign step.count = index;

    // Last rope pixel and last arc point
    assign step.ropeEnd = (index == stepCount'(`HOOK_ROPE_STEPS - 1));
    assign step.arcEnd  = (index == stepCount'(`HOOK_ARC_STEPS - 1));

endmodule

// File: hook/trig_table.sv
//****************************************
// Sine and cosine lookup
// Quadrant fold, magnitudes x100, signs
//****************************************

module trigTable import hookPkg::*; (
    input  logic [8:0] angle,
    output trigPair    trig
);

    // round(100 * sin(k)) for k = 0 to 90 degrees
    localparam logic [6:0] SinTab [0:90] = '{
        7'd0,   7'd2,   7'd3,   7'd5,   7'd7,   7'd9,   7'd10,  7'd12,  7'd14,  7'd16,
        7'd17,  7'd19,  7'd21,  7'd22,  7'd24,  7'd26,  7'd28,  7'd29,  7'd31,  7'd33,
        7'd34,  7'd36,  7'd37,  7'd39,  7'd41,  7'd42,  7'd44,  7'd45,  7'd47,  7'd48,
        7'd50,  7'd52,  7'd53,  7'd54,  7'd56,  7'd57,  7'd59,  7'd60,  7'd62,  7'd63,
        7'd64,  7'd66,  7'd67,  7'd68,  7'd69,  7'd71,  7'd72,  7'd73,  7'd74,  7'd75,
        7'd77,  7'd78,  7'd79,  7'd80,  7'd81,  7'd82,  7'd83,  7'd84,  7'd85,  7'd86,
        7'd87,  7'd87,  7'd88,  7'd89,  7'd90,  7'd91,  7'd91,  7'd92,  7'd93,  7'd93,
        7'd94,  7'd95,  7'd95,  7'd96,  7'd96,  7'd97,  7'd97,  7'd97,  7'd98,  7'd98,
        7'd98,  7'd99,  7'd99,  7'd99,  7'd99,  7'd100, 7'd100, 7'd100, 7'd100, 7'd100,
        7'd100
    };

    logic [6:0] foldAngle;
    logic [6:0] cosIdx;

    always_comb begin
        // Reduce to a first quadrant angle
        if (angle <= 9'd90) begin
            foldAngle   = 7'(angle);
            trig.cosNeg = 1'b0;
            trig.sinNeg = 1'b0;
        end else if (angle <= 9'd180) begin
            foldAngle   = 7'(9'd180 - angle);
            trig.cosNeg = 1'b1;
            trig.sinNeg = 1'b0;
        end else if (angle <= 9'd270) begin
            foldAngle   = 7'(angle - 9'd180);
            trig.cosNeg = 1'b1;
            trig.sinNeg = 1'b1;
        end else if (angle < 9'd360) begin
            foldAngle   = 7'(9'd360 - angle);
            trig.cosNeg = 1'b0;
            trig.sinNeg = 1'b1;
        end else begin
            foldAngle   = 7'd0;  // Out of range angles read as zero
            trig.cosNeg = 1'b0;
            trig.sinNeg = 1'b0;
        end

        cosIdx      = 7'd90 - foldAngle;  // cos(a) = sin(90 - a)
        trig.sinMag = SinTab[foldAngle];
        trig.cosMag = SinTab[cosIdx];
    end

endmodule

// File: hook/arc_tracer.sv
//****************************************
// Arc point generator
// Angle from step index, point, gap mask
//****************************************

`include "hook_cfg.svh"

module arcTracer import hookPkg::*; (
    stepBus.user       step,
    input  logic [8:0] degree,
    input  xCoord      tipX,
    input  yCoord      tipY,
    input  trigPair    trig,
    output logic [8:0] arcAngle,
    output xCoord      arcX,
    output yCoord      arcY,
    output logic       drawMask
);

    logic [11:0] prodX;    // Radius times magnitude, at most 2000
    logic [11:0] prodY;
    logic [4:0]  offX;
    logic [4:0]  offY;
    logic [9:0]  gapEnd;   // Upper edge of the mouth

    // 0, 5, ... 355 degrees
    assign arcAngle = 9'(step.count) * 9'(`HOOK_ARC_STEP);

    // Offsets are floored magnitudes, the sign is applied afterwards
    assign prodX = 12'(`HOOK_RADIUS) * 12'(trig.cosMag);
    assign prodY = 12'(`HOOK_RADIUS) * 12'(trig.sinMag);
    assign offX  = 5'(prodX / 12'(`HOOK_TRIG_SCALE));
    assign offY  = 5'(prodY / 12'(`HOOK_TRIG_SCALE));

    assign arcX = trig.cosNeg ? tipX - xCoord'(offX) : tipX + xCoord'(offX);
    assign arcY = trig.sinNeg ? tipY - yCoord'(offY) : tipY + yCoord'(offY);

    // Skip points inside [degree, degree + gap]
    assign gapEnd   = 10'(degree) + 10'(`HOOK_GAP);
    assign drawMask = (arcAngle < degree) || (10'(arcAngle) > gapEnd);

endmodule

// File: hook/point_plotter.sv
//****************************************
// Pixel output stage
// Tip latch, rope interpolation,
// registered coordinates and strobes
//****************************************

`include "hook_cfg.svh"

module pointPlotter import hookPkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  drawState   state,
    stepBus.user       step,
    input  logic [9:0] length,
    input  trigPair    tipTrig,
    input  xCoord      arcX,
    input  yCoord      arcY,
    input  logic       drawMask,
    output xCoord      tipX,
    output yCoord      tipY,
    output xCoord      outX,
    output yCoord      outY,
    output logic       writeEn,
    output logic       done
);

    localparam int FracBits = $clog2(`HOOK_ROPE_STEPS);

    logic [16:0]        reachX;     // length * magnitude
    logic [16:0]        reachY;
    logic [9:0]         tipOffX;
    logic [9:0]         tipOffY;
    xCoord              tipXNext;
    yCoord              tipYNext;
    logic signed [8:0]  ropeDx;
    logic signed [8:0]  ropeDy;
    logic signed [8:0]  ropeT;
    logic signed [17:0] ropeMulX;
    logic signed [17:0] ropeMulY;
    xCoord              ropeX;
    yCoord              ropeY;

    always_comb begin
        // Tip position from length and swing
        reachX   = 17'(length) * 17'(tipTrig.cosMag);
        reachY   = 17'(length) * 17'(tipTrig.sinMag);
        tipOffX  = 10'(reachX / 17'(`HOOK_TRIG_SCALE));
        tipOffY  = 10'(reachY / 17'(`HOOK_TRIG_SCALE));
        tipXNext = tipTrig.cosNeg ? xCoord'(`HOOK_START_X) - xCoord'(tipOffX)
                                  : xCoord'(`HOOK_START_X) + xCoord'(tipOffX);
        tipYNext = yCoord'(`HOOK_START_Y) + yCoord'(tipOffY);

        // Rope point, floor of the signed fraction
        ropeT    = signed'({1'b0, step.count});
        ropeDx   = signed'(tipX - xCoord'(`HOOK_START_X));
        ropeDy   = signed'({1'b0, tipY} - 9'(`HOOK_START_Y));
        ropeMulX = ropeDx * ropeT;
        ropeMulY = ropeDy * ropeT;
        ropeX    = xCoord'(`HOOK_START_X) + xCoord'(ropeMulX >>> FracBits);
        ropeY    = yCoord'(`HOOK_START_Y) + yCoord'(ropeMulY >>> FracBits);
    end

    always_ff @(posedge clock) begin
        if (state == Setup) begin
            tipX <= tipXNext;
            tipY <= tipYNext;
        end

        case (state)
            Rope: begin
                outX <= ropeX;
                outY <= ropeY;
            end
            Arc: begin
                outX <= arcX;
                outY <= arcY;
            end
            default: begin
                outX <= outX;  // Hold last pixel
                outY <= outY;
            end
        endcase
    end

    // Strobes
    always_ff @(posedge clock) begin
        if (!resetn) begin
            writeEn <= 1'b0;
            done    <= 1'b0;
        end else begin
            writeEn <= (state == Rope) || ((state == Arc) && drawMask);
            done    <= (state == Done);
        end
    end

endmodule

// File: src/hook_renderer.sv
//****************************************
// Hook renderer top level
// Sequencer, counter, trig lookups,
// arc tracer and pixel output stage
//****************************************

`include "hook_cfg.svh"

module hookRenderer import hookPkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic [9:0] length,
    input  logic [8:0] degree,
    output logic [8:0] outX,
    output logic [7:0] outY,
    output logic       writeEn,
    output logic       done
);

    drawState   state;
    logic [9:0] tipSum;
    logic [8:0] tipAngle;
    logic [8:0] arcAngle;
    trigPair    tipTrig;
    trigPair    arcTrig;
    xCoord      tipX;
    yCoord      tipY;
    xCoord      arcX;
    yCoord      arcY;
    logic       drawMask;

    stepBus step ();

    // Tip direction, (degree + offset) mod 360
    assign tipSum   = 10'(degree) + 10'(`HOOK_TIP_OFFSET);
    assign tipAngle = (tipSum >= 10'(`HOOK_FULL_TURN)) ? 9'(tipSum - 10'(`HOOK_FULL_TURN))
                                                      : tipSum[8:0];

    hookDrawFsm i_fsm (
        .clock  (clock),
        .resetn (resetn),
        .enable (enable),
        .step   (step.ctrl),
        .state  (state)
    );

    stepCounter i_counter (
        .clock  (clock),
        .resetn (resetn),
        .step   (step.cnt)
    );

    trigTable i_tipTrig (
        .angle (tipAngle),
        .trig  (tipTrig)
    );

    trigTable i_arcTrig (
        .angle (arcAngle),
        .trig  (arcTrig)
    );

    arcTracer i_arc (
        .step     (step.user),
        .degree   (degree),
        .tipX     (tipX),
        .tipY     (tipY),
        .trig     (arcTrig),
        .arcAngle (arcAngle),
        .arcX     (arcX),
        .arcY     (arcY),
        .drawMask (drawMask)
    );

    pointPlotter i_plotter (
        .clock    (clock),
        .resetn   (resetn),
        .state    (state),
        .step     (step.user),
        .length   (length),
        .tipTrig  (tipTrig),
        .arcX     (arcX),
        .arcY     (arcY),
        .drawMask (drawMask),
        .tipX     (tipX),
        .tipY     (tipY),
        .outX     (outX),
        .outY     (outY),
        .writeEn  (writeEn),
        .done     (done)
    );

endmodule

// File: testbench/hook_checker.sv
//****************************************
// Bound protocol assertions
// Done pulse, write strobe, idle start
//****************************************

module hookFsmChecker import hookPkg::*; (
    input logic     clock,
    input logic     resetn,
    input drawState state,
    input logic     enable
);

    timeunit 1ns;
    timeprecision 1ps;

    startDraw: assert property (@(posedge clock) disable iff (!resetn)
        (state == Idle && enable) |=> (state == Setup))
        else $error("enable in idle did not lead to setup");

endmodule

module hookPlotChecker import hookPkg::*; (
    input logic     clock,
    input logic     resetn,
    input drawState state,
    input logic     writeEn,
    input logic     done
);

    timeunit 1ns;
    timeprecision 1ps;

    doneSingle: assert property (@(posedge clock) disable iff (!resetn) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Last arc pixel may still leave during Done
    quietStates: assert property (@(posedge clock) disable iff (!resetn)
        (state == Idle || state == Setup) |-> !writeEn)
        else $error("writeEn high while idle or in setup");

endmodule

// FSM side sees enable, plotter side sees the strobes
bind hookDrawFsm hookFsmChecker i_fsmCheck (
    .clock  (clock),
    .resetn (resetn),
    .state  (state),
    .enable (enable)
);

bind pointPlotter hookPlotChecker i_plotCheck (
    .clock   (clock),
    .resetn  (resetn),
    .state   (state),
    .writeEn (writeEn),
    .done    (done)
);

// File: testbench/hook_tb.sv
//****************************************
// Hook renderer testbench
// Stimulus, reference pixel model,
// compare tasks, watchdog and summary
//****************************************

`include "hook_cfg.svh"

module hookTb import hookPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  ClockPeriod = 100;
    localparam int  NumTests    = 25;
    localparam int  WatchdogCycles = NumTests * 340 + 200;
    localparam real Pi = 3.14159265358979;
    // Enable sample, setup, output register, then one pixel per clock
    localparam int  DoneCycles = 3 + `HOOK_ROPE_STEPS + `HOOK_ARC_STEPS;

    logic       clock;
    logic       resetn;
    logic       enable;
    logic [9:0] length;
    logic [8:0] degree;
    xCoord      outX;
    yCoord      outY;
    logic       writeEn;
    logic       done;

    xCoord      expX[$];
    yCoord      expY[$];
    string      testName;
    int         writeCount;
    int         errorCount;
    int         testErrors;
    int         testCount;
    int         failedTests;
    bit [31:0]  rngState = 32'd64;

    hookRenderer i_dut (
        .clock   (clock),
        .resetn  (resetn),
        .enable  (enable),
        .length  (length),
        .degree  (degree),
        .outX    (outX),
        .outY    (outY),
        .writeEn (writeEn),
        .done    (done)
    );

    always #(ClockPeriod / 2) clock = ~clock;

    function automatic bit [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int floorDiv(int n, int d);
        if (n >= 0) begin
            return n / d;
        end
        return -((-n + d - 1) / d);
    endfunction

    // Rounded magnitudes x100 and signs, straight from the real functions
    function automatic void trigRef(input int ang, output int cMag, output int sMag,
                                    output bit cNeg, output bit sNeg);
        real c;
        real s;
        c    = $cos(ang * Pi / 180.0);
        s    = $sin(ang * Pi / 180.0);
        cNeg = (c < 0.0);
        sNeg = (s < 0.0);
        cMag = $rtoi((cNeg ? -c : c) * 100.0 + 0.5);
        sMag = $rtoi((sNeg ? -s : s) * 100.0 + 0.5);
    endfunction

    // Expected written pixels, rope first then the arc outside the mouth
    function automatic void buildExpected(int len, int deg);
        int cMag;
        int sMag;
        bit cNeg;
        bit sNeg;
        int tipX;
        int tipY;
        int offX;
        int offY;
        int ang;
        expX.delete();
        expY.delete();
        trigRef((deg + `HOOK_TIP_OFFSET) % `HOOK_FULL_TURN, cMag, sMag, cNeg, sNeg);
        offX = len * cMag / 100;
        tipX = cNeg ? `HOOK_START_X - offX : `HOOK_START_X + offX;
        tipY = `HOOK_START_Y + len * sMag / 100;
        for (int t = 0; t < `HOOK_ROPE_STEPS; t++) begin
            expX.push_back(xCoord'(`HOOK_START_X
                + floorDiv((tipX - `HOOK_START_X) * t, `HOOK_ROPE_STEPS)));
            expY.push_back(yCoord'(`HOOK_START_Y
                + floorDiv((tipY - `HOOK_START_Y) * t, `HOOK_ROPE_STEPS)));
        end
        for (int k = 0; k < `HOOK_ARC_STEPS; k++) begin
            ang = k * `HOOK_ARC_STEP;
            trigRef(ang, cMag, sMag, cNeg, sNeg);
            offX = `HOOK_RADIUS * cMag / 100;
            offY = `HOOK_RADIUS * sMag / 100;
            if (ang < deg || ang > deg + `HOOK_GAP) begin
                expX.push_back(xCoord'(cNeg ? tipX - offX : tipX + offX));
                expY.push_back(yCoord'(sNeg ? tipY - offY : tipY + offY));
            end
        end
    endfunction

    task automatic noteFailure();
        errorCount++;
        testErrors++;
    endtask

    task automatic checkX(string what, xCoord expected, xCoord actual);
        if (actual !== expected) begin
            $display("** Error %0s %0s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            noteFailure();
        end
    endtask

    task automatic checkY(string what, yCoord expected, yCoord actual);
        if (actual !== expected) begin
            $display("** Error %0s %0s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            noteFailure();
        end
    endtask

    task automatic checkCount(string what, int expected, int actual);
        if (actual !== expected) begin
            $display("** Error %0s %0s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            noteFailure();
        end
    endtask

    // Pixel monitor, compares every written pixel in order
    always @(negedge clock) begin
        if (resetn && writeEn) begin
            writeCount++;
            if (expX.size() == 0) begin
                $display("Error in %0s: pixel write (%0d, %0d) beyond the expected list",
                         testName, outX, outY);
                noteFailure();
            end else begin
                checkX("outX", expX.pop_front(), outX);
                checkY("outY", expY.pop_front(), outY);
            end
        end
    end

    task automatic startTest(string name);
        testName   = name;
        testErrors = 0;
        testCount++;
    endtask

    task automatic endTest();
        if (testErrors > 0) begin
            failedTests++;
        end
        $display("test %-12s %0s", testName, (testErrors == 0) ? "ok" : "failed");
    endtask

    // One full drawing, optional enable pulses in the rope and arc phases
    task automatic runCase(string name, int len, int deg, bit busy);
        int cycles;
        int expectedWrites;
        startTest(name);
        buildExpected(len, deg);
        expectedWrites = expX.size();
        writeCount     = 0;
        length         = 10'(len);
        degree         = 9'(deg);
        enable         = 1'b1;
        cycles         = 0;
        while (cycles < DoneCycles + 20) begin
            @(posedge clock);
            #10;
            cycles++;
            enable = busy && (cycles == 50 || cycles == 300);
            if (done) begin
                break;
            end
        end
        if (!done) begin
            $display("Error in %0s: done never arrived", testName);
            noteFailure();
        end else begin
            checkCount("done cycle", DoneCycles, cycles);
        end
        @(posedge clock);
        #10;
        checkCount("done width", 0, int'(done));
        repeat (2) @(posedge clock);
        #10;
        checkCount("write count", expectedWrites, writeCount);
        endTest();
    endtask

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clock  = 1'b0;
        resetn = 1'b0;
        enable = 1'b0;
        length = '0;
        degree = '0;
        repeat (2) @(posedge clock);
        #10 resetn = 1'b1;

        startTest("reset idle");
        repeat (5) begin
            @(posedge clock);
            #10;
            checkCount("writeEn", 0, int'(writeEn));
            checkCount("done", 0, int'(done));
        end
        endTest();

        runCase("fixed 0/0", 0, 0, 1'b0);
        runCase("fixed 100/70", 100, 70, 1'b0);
        runCase("fixed 200/140", 200, 140, 1'b0);
        runCase("busy enable", 150, 30, 1'b1);
        for (int i = 0; i < 20; i++) begin
            runCase($sformatf("random %0d", i), int'(nextRandom() % 201),
                    int'(nextRandom() % 141), 1'b0);
        end

        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/hook_pkg.sv
common/step_if.sv
hook/hook_draw_fsm.sv
hook/step_counter.sv
hook/trig_table.sv
hook/arc_tracer.sv
hook/point_plotter.sv
src/hook_renderer.sv
testbench/hook_checker.sv
testbench/hook_tb.sv

// File: Makefile
TOP = hookTb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
